// File: lc4_superscalar.f
+incdir+verilog
verilog/lc4_pkg.sv
verilog/lc4_reg_write_if.sv
verilog/lc4_fetch_pair.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile_2w.sv
verilog/lc4_decode_stage.sv
verilog/lc4_execute_stage.sv
verilog/lc4_memory_wb.sv
verilog/lc4_superscalar.sv
testbench/tb_lc4_superscalar.sv

// File: Bender.yml
package:
  name: lc4_superscalar

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lc4_pkg.sv
      - verilog/lc4_reg_write_if.sv
      - verilog/lc4_fetch_pair.sv
      - verilog/lc4_decoder.sv
      - verilog/lc4_regfile_2w.sv
      - verilog/lc4_decode_stage.sv
      - verilog/lc4_execute_stage.sv
      - verilog/lc4_memory_wb.sv
      - verilog/lc4_superscalar.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_lc4_superscalar.sv

// File: testbench/lc4_testdata.txt
# P addr insn | D addr data | T test name, followed by one A and one B line per trace cycle
# A/B: stall pc insn rf_we wsel rf_data nzp_we nzp dmem_we dmem_addr dmem_data (hex)
P 8200 9205
P 8201 95fd
P 8202 9600
P 8203 9840
P 8206 1a42
P 8207 1c52
P 8208 1ebb
P 8209 16e0
P 820c 1260
P 820d 1041
P 820f 7d02
P 8211 6702
P 8213 653f
P 8214 6b00
P 8216 9e11
P 8217 9e22
P 821c 13e0
D 003f 8001
D 0040 0000
# nop pair fetched while reset was held
T reset
A 0 8200 0000 0 0 0000 0 0 0 0000 0000
B 0 8201 0000 0 0 0000 0 0 0 0000 0000
T independent
A 0 8200 9205 1 1 0005 1 1 0 0000 0000
B 0 8201 95fd 1 2 fffd 1 4 0 0000 0000
A 0 8202 9600 1 3 0000 1 2 0 0000 0000
B 0 8203 9840 1 4 0040 1 1 0 0000 0000
A 0 8204 0000 0 0 0000 0 0 0 0000 0000
B 0 8205 0000 0 0 0000 0 0 0 0000 0000
A 0 8206 1a42 1 5 0002 1 1 0 0000 0000
B 0 8207 1c52 1 6 0008 1 1 0 0000 0000
A 0 8208 1ebb 1 7 fff8 1 4 0 0000 0000
B 0 8209 16e0 1 3 0000 1 2 0 0000 0000
A 0 820a 0000 0 0 0000 0 0 0 0000 0000
B 0 820b 0000 0 0 0000 0 0 0 0000 0000
# r1 is rewritten with its own value so the replayed reader sees 5 either way
T dependent
A 0 820c 1260 1 1 0005 1 1 0 0000 0000
B 1 820d 1041 0 0 0000 0 0 0 0000 0000
A 0 820d 1041 1 0 000a 1 1 0 0000 0000
B 0 820e 0000 0 0 0000 0 0 0 0000 0000
T memory
A 0 820f 7d02 0 0 0000 0 0 1 0042 0008
B 0 8210 0000 0 0 0000 0 0 0 0000 0000
A 0 8211 6702 1 3 0008 1 1 0 0042 0008
B 0 8212 0000 0 0 0000 0 0 0 0000 0000
A 0 8213 653f 1 2 8001 1 4 0 003f 8001
B 1 8214 6b00 0 0 0000 0 0 0 0000 0000
A 0 8214 6b00 1 5 0000 1 2 0 0040 0000
B 0 8215 0000 0 0 0000 0 0 0 0000 0000
T same_dest
A 0 8216 9e11 1 7 0011 1 1 0 0000 0000
B 0 8217 9e22 1 7 0022 1 1 0 0000 0000
A 0 8218 0000 0 0 0000 0 0 0 0000 0000
B 0 8219 0000 0 0 0000 0 0 0 0000 0000
A 0 821a 0000 0 0 0000 0 0 0 0000 0000
B 0 821b 0000 0 0 0000 0 0 0 0000 0000
A 0 821c 13e0 1 1 0022 1 1 0 0000 0000
B 0 821d 0000 0 0 0000 0 0 0 0000 0000

// File: testbench/tb_lc4_superscalar.sv
`timescale 1ns/1ps

module tb_lc4_superscalar;

   localparam int RESET_CYCLES  = 3;
   localparam int FIRST_TIMEOUT = 40;   // cycles allowed for the first record after reset
   localparam lc4_pkg::word_t RESET_PC = 16'h8200;

   typedef struct {
      lc4_pkg::stall_t   stall;
      lc4_pkg::word_t    pc;
      lc4_pkg::word_t    insn;
      logic              rf_we;
      lc4_pkg::reg_sel_t wsel;
      lc4_pkg::word_t    rf_data;
      logic              nzp_we;
      lc4_pkg::nzp_t     nzp;
      logic              dmem_we;
      lc4_pkg::word_t    dmem_addr;
      lc4_pkg::word_t    dmem_data;
   } trace_t;

   logic              gwe;
   logic              i_reset;
   lc4_pkg::word_t    o_cur_pc, i_insn_a, i_insn_b;
   lc4_pkg::word_t    o_dmem_addr, o_dmem_towrite, i_dmem_data;
   logic              o_dmem_we;
   lc4_pkg::stall_t   o_trace_stall_a, o_trace_stall_b;
   lc4_pkg::word_t    o_trace_pc_a, o_trace_pc_b, o_trace_insn_a, o_trace_insn_b;
   logic              o_trace_rf_we_a, o_trace_rf_we_b;
   lc4_pkg::reg_sel_t o_trace_rf_wsel_a, o_trace_rf_wsel_b;
   lc4_pkg::word_t    o_trace_rf_data_a, o_trace_rf_data_b;
   logic              o_trace_nzp_we_a, o_trace_nzp_we_b;
   lc4_pkg::nzp_t     o_trace_nzp_a, o_trace_nzp_b;
   logic              o_trace_dmem_we_a, o_trace_dmem_we_b;
   lc4_pkg::word_t    o_trace_dmem_addr_a, o_trace_dmem_addr_b;
   lc4_pkg::word_t    o_trace_dmem_data_a, o_trace_dmem_data_b;

   lc4_pkg::word_t imem [lc4_pkg::word_t];
   lc4_pkg::word_t dmem [0:65535];
   string          test_names [$];
   int             rec_test [$];   // test index of each record
   trace_t         exp_a [$];
   trace_t         exp_b [$];
   string          cur_name = "reset";
   int             cycle = 0;
   int             errors = 0;
   int             test_errors = 0;
   int             passed = 0;
   int             failed = 0;

   lc4_superscalar u_dut (.*);

   always #2 gwe = ~gwe;

   function automatic lc4_pkg::word_t fetch_word(input lc4_pkg::word_t addr);
      if (imem.exists(addr))
         return imem[addr];
      return '0;   // unwritten locations read as nop
   endfunction

   // imem answers one cycle late, and reads zero while reset is held
   always @(posedge gwe) begin
      cycle <= cycle + 1;
      if (i_reset) begin
         i_insn_a <= '0;
         i_insn_b <= '0;
      end else begin
         i_insn_a <= fetch_word(o_cur_pc);
         i_insn_b <= fetch_word(o_cur_pc + 16'd1);
      end
      if (!i_reset && o_dmem_we)
         dmem[o_dmem_addr] <= o_dmem_towrite;
   end

   assign i_dmem_data = dmem[o_dmem_addr];   // same-cycle load data

   task automatic load_testdata();
      int     fd;
      string  line;
      string  tag;
      string  name;
      int     a;
      int     d;
      int     f [11];
      trace_t t;
      for (int i = 0; i < 65536; i++)
         dmem[i] = lc4_pkg::word_t'(i) ^ 16'hc3a5;
      fd = $fopen("testbench/lc4_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open testbench/lc4_testdata.txt");
         errors++;
      end else begin
         while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s", tag) != 1 || tag.substr(0, 0) == "#")
               continue;
            case (tag)
               "P": if ($sscanf(line, "%s %h %h", tag, a, d) == 3) imem[a] = d;
               "D": if ($sscanf(line, "%s %h %h", tag, a, d) == 3) dmem[a] = d;
               "T": if ($sscanf(line, "%s %s", tag, name) == 2) test_names.push_back(name);
               "A", "B": begin
                  if ($sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", tag, f[0], f[1],
                              f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]) != 12) begin
                     $display("malformed record line in test data: %s", line);
                     errors++;
                  end
                  t = '{stall: lc4_pkg::stall_t'(f[0]), pc: f[1], insn: f[2], rf_we: f[3][0],
                        wsel: f[4], rf_data: f[5], nzp_we: f[6][0], nzp: f[7],
                        dmem_we: f[8][0], dmem_addr: f[9], dmem_data: f[10]};
                  if (tag == "A") begin
                     exp_a.push_back(t);
                     rec_test.push_back(test_names.size() - 1);
                  end else begin
                     exp_b.push_back(t);
                  end
               end
               default: begin
                  $display("unknown line in test data: %s", line);
                  errors++;
               end
            endcase
         end
         $fclose(fd);
      end
      if (exp_a.size() != exp_b.size() || exp_a.size() == 0) begin
         $display("test data holds %0d A and %0d B records", exp_a.size(), exp_b.size());
         errors++;
      end
   endtask

   task automatic check_word(input string what, input lc4_pkg::word_t exp,
                             input lc4_pkg::word_t act);
      if (act !== exp) begin
         $display("** Error: %s %s expected %h actual %h", cur_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_sel(input string what, input lc4_pkg::reg_sel_t exp,
                            input lc4_pkg::reg_sel_t act);
      if (act !== exp) begin
         $display("** Error: %s %s expected %0d actual %0d", cur_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_nzp(input string what, input lc4_pkg::nzp_t exp,
                            input lc4_pkg::nzp_t act);
      if (act !== exp) begin
         $display("** Error: %s %s expected %b actual %b", cur_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_stall(input string what, input lc4_pkg::stall_t exp,
                              input lc4_pkg::stall_t act);
      if (act !== exp) begin
         $display("** Error: %s %s expected %0d actual %0d", cur_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error: %s %s expected %b actual %b", cur_name, what, exp, act);
         test_errors++;
      end
   endtask

   function automatic trace_t sample_trace_a();
      return '{stall: o_trace_stall_a, pc: o_trace_pc_a, insn: o_trace_insn_a,
               rf_we: o_trace_rf_we_a, wsel: o_trace_rf_wsel_a, rf_data: o_trace_rf_data_a,
               nzp_we: o_trace_nzp_we_a, nzp: o_trace_nzp_a, dmem_we: o_trace_dmem_we_a,
               dmem_addr: o_trace_dmem_addr_a, dmem_data: o_trace_dmem_data_a};
   endfunction

   function automatic trace_t sample_trace_b();
      return '{stall: o_trace_stall_b, pc: o_trace_pc_b, insn: o_trace_insn_b,
               rf_we: o_trace_rf_we_b, wsel: o_trace_rf_wsel_b, rf_data: o_trace_rf_data_b,
               nzp_we: o_trace_nzp_we_b, nzp: o_trace_nzp_b, dmem_we: o_trace_dmem_we_b,
               dmem_addr: o_trace_dmem_addr_b, dmem_data: o_trace_dmem_data_b};
   endfunction

   // data fields only matter on a retiring slot, and then only where enabled
   task automatic compare_pipe(input string pipe, input trace_t exp, input trace_t act);
      check_stall({pipe, " stall"}, exp.stall, act.stall);
      check_word({pipe, " pc"}, exp.pc, act.pc);
      check_word({pipe, " insn"}, exp.insn, act.insn);
      check_bit({pipe, " rf_we"}, exp.rf_we, act.rf_we);
      check_bit({pipe, " nzp_we"}, exp.nzp_we, act.nzp_we);
      check_bit({pipe, " dmem_we"}, exp.dmem_we, act.dmem_we);
      if (exp.stall == lc4_pkg::STALL_NONE) begin
         if (exp.rf_we) begin
            check_sel({pipe, " wsel"}, exp.wsel, act.wsel);
            check_word({pipe, " rf_data"}, exp.rf_data, act.rf_data);
         end
         if (exp.nzp_we)
            check_nzp({pipe, " nzp"}, exp.nzp, act.nzp);
         check_word({pipe, " dmem_addr"}, exp.dmem_addr, act.dmem_addr);
         check_word({pipe, " dmem_data"}, exp.dmem_data, act.dmem_data);
      end
   endtask

   task automatic finish_test();
      if (test_errors == 0) begin
         $display("test %s: ok", cur_name);
         passed++;
      end else begin
         $display("test %s: %0d mismatches", cur_name, test_errors);
         failed++;
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   task automatic run_records();
      int last_test;
      last_test = 0;
      // the fetch register loads the pair presented at the last reset edge
      if (cycle != RESET_CYCLES + 4) begin
         $display("first trace record came at cycle %0d instead of cycle %0d",
                  cycle, RESET_CYCLES + 4);
         test_errors++;
      end
      for (int r = 0; r < exp_a.size(); r++) begin
         if (r > 0) begin
            @(posedge gwe);
            @(negedge gwe);
         end
         if (rec_test[r] != last_test) begin
            finish_test();
            last_test = rec_test[r];
            cur_name  = test_names[last_test];
         end
         compare_pipe("A", exp_a[r], sample_trace_a());
         compare_pipe("B", exp_b[r], sample_trace_b());
      end
      finish_test();
   endtask

   initial begin
      int waited;
      gwe      = 1'b0;
      i_reset  = 1'b1;
      i_insn_a = '0;
      i_insn_b = '0;
      load_testdata();
      if (test_names.size() > 0)
         cur_name = test_names[0];
      for (int k = 1; k <= RESET_CYCLES; k++) begin
         @(posedge gwe);
         if (k == RESET_CYCLES)
            i_reset <= 1'b0;
         @(negedge gwe);
         check_word("cur_pc in reset", RESET_PC, o_cur_pc);
         check_bit("dmem_we in reset", 1'b0, o_dmem_we);
      end
      waited = 0;
      do begin   // flushed slots drain out of writeback first
         @(posedge gwe);
         @(negedge gwe);
         waited++;
         if (o_trace_stall_a == lc4_pkg::STALL_FLUSH) begin
            check_stall("B stall flush", lc4_pkg::STALL_FLUSH, o_trace_stall_b);
            check_bit("A rf_we flush", 1'b0, o_trace_rf_we_a);
            check_bit("A nzp_we flush", 1'b0, o_trace_nzp_we_a);
            check_bit("A dmem_we flush", 1'b0, o_trace_dmem_we_a);
            check_bit("B rf_we flush", 1'b0, o_trace_rf_we_b);
            check_bit("B nzp_we flush", 1'b0, o_trace_nzp_we_b);
            check_bit("B dmem_we flush", 1'b0, o_trace_dmem_we_b);
            check_bit("dmem_we flush", 1'b0, o_dmem_we);
         end
      end while (o_trace_stall_a == lc4_pkg::STALL_FLUSH && waited < FIRST_TIMEOUT);
      if (o_trace_stall_a == lc4_pkg::STALL_FLUSH) begin
         $display("timed out: no trace record left the flush state within %0d cycles",
                  FIRST_TIMEOUT);
         errors += test_errors + 1;
      end else begin
         run_records();
      end
      $display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
      if (errors == 0 && failed == 0 && passed > 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: verilog/lc4_superscalar.sv
`timescale 1ns/1ps

module lc4_superscalar (
   input  logic              gwe,
   input  logic              i_reset,
   output lc4_pkg::word_t    o_cur_pc,
   input  lc4_pkg::word_t    i_insn_a,
   input  lc4_pkg::word_t    i_insn_b,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_towrite,
   input  lc4_pkg::word_t    i_dmem_data,
   output lc4_pkg::stall_t   o_trace_stall_a,
   output lc4_pkg::stall_t   o_trace_stall_b,
   output lc4_pkg::word_t    o_trace_pc_a,
   output lc4_pkg::word_t    o_trace_pc_b,
   output lc4_pkg::word_t    o_trace_insn_a,
   output lc4_pkg::word_t    o_trace_insn_b,
   output logic              o_trace_rf_we_a,
   output logic              o_trace_rf_we_b,
   output lc4_pkg::reg_sel_t o_trace_rf_wsel_a,
   output lc4_pkg::reg_sel_t o_trace_rf_wsel_b,
   output lc4_pkg::word_t    o_trace_rf_data_a,
   output lc4_pkg::word_t    o_trace_rf_data_b,
   output logic              o_trace_nzp_we_a,
   output logic              o_trace_nzp_we_b,
   output lc4_pkg::nzp_t     o_trace_nzp_a,
   output lc4_pkg::nzp_t     o_trace_nzp_b,
   output logic              o_trace_dmem_we_a,
   output logic              o_trace_dmem_we_b,
   output lc4_pkg::word_t    o_trace_dmem_addr_a,
   output lc4_pkg::word_t    o_trace_dmem_addr_b,
   output lc4_pkg::word_t    o_trace_dmem_data_a,
   output lc4_pkg::word_t    o_trace_dmem_data_b
);

   logic           split;
   lc4_pkg::slot_t f_slot_a, f_slot_b;   // fetch to decode
   lc4_pkg::slot_t d_slot_a, d_slot_b;   // decode to execute
   lc4_pkg::word_t d_rs_a, d_rt_a, d_rs_b, d_rt_b;
   lc4_pkg::slot_t x_slot_a, x_slot_b;   // execute to memory
   lc4_pkg::word_t x_result_a, x_result_b, x_store_a, x_store_b;

   lc4_reg_write_if u_wr ();

   // remaining fetch ports share names with the top level
   lc4_fetch_pair u_fetch (
      .i_split(split), .o_slot_a(f_slot_a), .o_slot_b(f_slot_b),
      .*
   );

   lc4_decode_stage u_decode (
      .gwe, .i_reset,
      .i_slot_a(f_slot_a), .i_slot_b(f_slot_b), .wr(u_wr.reader), .o_split(split),
      .o_slot_a(d_slot_a), .o_slot_b(d_slot_b),
      .o_rs_a(d_rs_a), .o_rt_a(d_rt_a), .o_rs_b(d_rs_b), .o_rt_b(d_rt_b)
   );

   lc4_execute_stage u_execute (
      .gwe, .i_reset,
      .i_slot_a(d_slot_a), .i_slot_b(d_slot_b),
      .i_rs_a(d_rs_a), .i_rt_a(d_rt_a), .i_rs_b(d_rs_b), .i_rt_b(d_rt_b),
      .o_slot_a(x_slot_a), .o_slot_b(x_slot_b),
      .o_result_a(x_result_a), .o_result_b(x_result_b),
      .o_store_a(x_store_a), .o_store_b(x_store_b)
   );

   // data port and trace outputs connect by name
   lc4_memory_wb u_memory_wb (
      .i_slot_a(x_slot_a), .i_slot_b(x_slot_b),
      .i_result_a(x_result_a), .i_result_b(x_result_b),
      .i_store_a(x_store_a), .i_store_b(x_store_b),
      .wr(u_wr.writer),
      .*
   );

endmodule

// File: verilog/lc4_memory_wb.sv
`timescale 1ns/1ps
`include "lc4_defs.svh"

module lc4_memory_wb (
   input  logic              gwe,
   input  logic              i_reset,
   input  lc4_pkg::slot_t    i_slot_a,
   input  lc4_pkg::slot_t    i_slot_b,
   input  lc4_pkg::word_t    i_result_a,
   input  lc4_pkg::word_t    i_result_b,
   input  lc4_pkg::word_t    i_store_a,
   input  lc4_pkg::word_t    i_store_b,
   input  lc4_pkg::word_t    i_dmem_data,
   output lc4_pkg::word_t    o_dmem_addr,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_towrite,
   lc4_reg_write_if.writer   wr,
   output lc4_pkg::stall_t   o_trace_stall_a,
   output lc4_pkg::stall_t   o_trace_stall_b,
   output lc4_pkg::word_t    o_trace_pc_a,
   output lc4_pkg::word_t    o_trace_pc_b,
   output lc4_pkg::word_t    o_trace_insn_a,
   output lc4_pkg::word_t    o_trace_insn_b,
   output logic              o_trace_rf_we_a,
   output logic              o_trace_rf_we_b,
   output lc4_pkg::reg_sel_t o_trace_rf_wsel_a,
   output lc4_pkg::reg_sel_t o_trace_rf_wsel_b,
   output lc4_pkg::word_t    o_trace_rf_data_a,
   output lc4_pkg::word_t    o_trace_rf_data_b,
   output logic              o_trace_nzp_we_a,
   output logic              o_trace_nzp_we_b,
   output lc4_pkg::nzp_t     o_trace_nzp_a,
   output lc4_pkg::nzp_t     o_trace_nzp_b,
   output logic              o_trace_dmem_we_a,
   output logic              o_trace_dmem_we_b,
   output lc4_pkg::word_t    o_trace_dmem_addr_a,
   output lc4_pkg::word_t    o_trace_dmem_addr_b,
   output lc4_pkg::word_t    o_trace_dmem_data_a,
   output lc4_pkg::word_t    o_trace_dmem_data_b
);

   // index 0 is pipe A, 1 is pipe B
   lc4_pkg::slot_t slot_m [2];
   lc4_pkg::word_t res_m [2], store_m [2];
   logic [1:0]     mem_m;   // pipe holds a load or store
   lc4_pkg::word_t wdata_m [2], taddr_m [2], tdata_m [2];
   lc4_pkg::nzp_t  nzp_m [2];

   lc4_pkg::slot_t slot_w [2];
   lc4_pkg::word_t wdata_w [2], taddr_w [2], tdata_w [2];
   lc4_pkg::nzp_t  nzp_w [2];

   assign slot_m  = '{i_slot_a, i_slot_b};
   assign res_m   = '{i_result_a, i_result_b};
   assign store_m = '{i_store_a, i_store_b};

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         mem_m[i]   = slot_m[i].ctrl.is_load || slot_m[i].ctrl.is_store;
         wdata_m[i] = slot_m[i].ctrl.is_load ? i_dmem_data : res_m[i];
         taddr_m[i] = mem_m[i] ? res_m[i] : '0;
         tdata_m[i] = slot_m[i].ctrl.is_load  ? i_dmem_data :
                      slot_m[i].ctrl.is_store ? store_m[i] : '0;
         if (wdata_m[i] == '0)
            nzp_m[i] = 3'b010;
         else if (wdata_m[i][`LC4_XLEN-1])
            nzp_m[i] = 3'b100;
         else
            nzp_m[i] = 3'b001;
      end
   end

   // decode never pairs two memory insns, so at most one pipe owns the port
   assign o_dmem_addr    = mem_m[1] ? res_m[1] : taddr_m[0];
   assign o_dmem_we      = slot_m[0].ctrl.is_store || slot_m[1].ctrl.is_store;
   assign o_dmem_towrite = mem_m[1] ? store_m[1] : store_m[0];

   always_ff @(posedge gwe) begin
      for (int i = 0; i < 2; i++) begin
         if (i_reset)
            slot_w[i] <= lc4_pkg::SLOT_FLUSH;
         else
            slot_w[i] <= slot_m[i];
         wdata_w[i] <= wdata_m[i];
         nzp_w[i]   <= nzp_m[i];
         taddr_w[i] <= taddr_m[i];
         tdata_w[i] <= tdata_m[i];
      end
   end

   assign wr.wr_a = '{we: slot_w[0].ctrl.rf_we, sel: slot_w[0].ctrl.wsel, data: wdata_w[0]};
   assign wr.wr_b = '{we: slot_w[1].ctrl.rf_we, sel: slot_w[1].ctrl.wsel, data: wdata_w[1]};

   assign o_trace_stall_a     = slot_w[0].stall;
   assign o_trace_stall_b     = slot_w[1].stall;
   assign o_trace_pc_a        = slot_w[0].pc;
   assign o_trace_pc_b        = slot_w[1].pc;
   assign o_trace_insn_a      = slot_w[0].insn;
   assign o_trace_insn_b      = slot_w[1].insn;
   assign o_trace_rf_we_a     = slot_w[0].ctrl.rf_we;
   assign o_trace_rf_we_b     = slot_w[1].ctrl.rf_we;
   assign o_trace_rf_wsel_a   = slot_w[0].ctrl.wsel;
   assign o_trace_rf_wsel_b   = slot_w[1].ctrl.wsel;
   assign o_trace_rf_data_a   = wdata_w[0];
   assign o_trace_rf_data_b   = wdata_w[1];
   assign o_trace_nzp_we_a    = slot_w[0].ctrl.nzp_we;
   assign o_trace_nzp_we_b    = slot_w[1].ctrl.nzp_we;
   assign o_trace_nzp_a       = nzp_w[0];
   assign o_trace_nzp_b       = nzp_w[1];
   assign o_trace_dmem_we_a   = slot_w[0].ctrl.is_store;
   assign o_trace_dmem_we_b   = slot_w[1].ctrl.is_store;
   assign o_trace_dmem_addr_a = taddr_w[0];
   assign o_trace_dmem_addr_b = taddr_w[1];
   assign o_trace_dmem_data_a = tdata_w[0];
   assign o_trace_dmem_data_b = tdata_w[1];

endmodule

// File: verilog/lc4_execute_stage.sv
`timescale 1ns/1ps

module lc4_execute_stage (
   input  logic           gwe,
   input  logic           i_reset,
   input  lc4_pkg::slot_t i_slot_a,
   input  lc4_pkg::slot_t i_slot_b,
   input  lc4_pkg::word_t i_rs_a,
   input  lc4_pkg::word_t i_rt_a,
   input  lc4_pkg::word_t i_rs_b,
   input  lc4_pkg::word_t i_rt_b,
   output lc4_pkg::slot_t o_slot_a,
   output lc4_pkg::slot_t o_slot_b,
   output lc4_pkg::word_t o_result_a,
   output lc4_pkg::word_t o_result_b,
   output lc4_pkg::word_t o_store_a,
   output lc4_pkg::word_t o_store_b
);

   function automatic lc4_pkg::word_t alu(input lc4_pkg::ctrl_t c,
                                          input lc4_pkg::word_t rs,
                                          input lc4_pkg::word_t rt);
      case (c.alu_op)
         lc4_pkg::ALU_ADD:  return rs + rt;
         lc4_pkg::ALU_SUB:  return rs - rt;
         lc4_pkg::ALU_ADDI: return rs + c.imm;
         default:           return c.imm;   // const
      endcase
   endfunction

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_slot_a <= lc4_pkg::SLOT_FLUSH;
         o_slot_b <= lc4_pkg::SLOT_FLUSH;
      end else begin
         o_slot_a <= i_slot_a;
         o_slot_b <= i_slot_b;
      end
      o_result_a <= alu(i_slot_a.ctrl, i_rs_a, i_rt_a);
      o_result_b <= alu(i_slot_b.ctrl, i_rs_b, i_rt_b);
      o_store_a  <= i_rt_a;   // STR data comes through the rt port
      o_store_b  <= i_rt_b;
   end

endmodule

// File: verilog/lc4_decode_stage.sv
`timescale 1ns/1ps

module lc4_decode_stage (
   input  logic                   gwe,
   input  logic                   i_reset,
   input  lc4_pkg::slot_t         i_slot_a,
   input  lc4_pkg::slot_t         i_slot_b,
   lc4_reg_write_if.reader        wr,
   output logic                   o_split,
   output lc4_pkg::slot_t         o_slot_a,
   output lc4_pkg::slot_t         o_slot_b,
   output lc4_pkg::word_t         o_rs_a,
   output lc4_pkg::word_t         o_rt_a,
   output lc4_pkg::word_t         o_rs_b,
   output lc4_pkg::word_t         o_rt_b
);

   lc4_pkg::ctrl_t ctrl_a;
   lc4_pkg::ctrl_t ctrl_b;
   lc4_pkg::word_t rs_a, rt_a, rs_b, rt_b;
   lc4_pkg::slot_t issue_b;
   logic           dep_ab;     // B reads what A writes
   logic           mem_pair;   // only one data port

   lc4_decoder u_dec_a (.i_insn(i_slot_a.insn), .o_ctrl(ctrl_a));
   lc4_decoder u_dec_b (.i_insn(i_slot_b.insn), .o_ctrl(ctrl_b));

   lc4_regfile_2w u_regfile (
      .gwe, .i_reset,
      .i_rs_a(ctrl_a.rs), .i_rt_a(ctrl_a.rt), .i_rs_b(ctrl_b.rs), .i_rt_b(ctrl_b.rt),
      .o_rs_data_a(rs_a), .o_rt_data_a(rt_a), .o_rs_data_b(rs_b), .o_rt_data_b(rt_b),
      .i_write_a(wr.wr_a), .i_write_b(wr.wr_b)
   );

   assign dep_ab = ctrl_a.rf_we &&
                   ((ctrl_b.rs_re && ctrl_b.rs == ctrl_a.wsel) ||
                    (ctrl_b.rt_re && ctrl_b.rt == ctrl_a.wsel));
   assign mem_pair = (ctrl_a.is_load || ctrl_a.is_store) &&
                     (ctrl_b.is_load || ctrl_b.is_store);
   assign o_split  = dep_ab || mem_pair;

   always_comb begin
      issue_b = '{pc: i_slot_b.pc, insn: i_slot_b.insn, ctrl: ctrl_b, stall: i_slot_b.stall};
      if (o_split) begin   // B becomes a bubble, fetch replays it as A
         issue_b.ctrl  = '0;
         issue_b.stall = lc4_pkg::STALL_SPLIT;
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_slot_a <= lc4_pkg::SLOT_FLUSH;
         o_slot_b <= lc4_pkg::SLOT_FLUSH;
      end else begin
         o_slot_a <= '{pc: i_slot_a.pc, insn: i_slot_a.insn, ctrl: ctrl_a,
                       stall: i_slot_a.stall};
         o_slot_b <= issue_b;
      end
      o_rs_a <= rs_a;
      o_rt_a <= rt_a;
      o_rs_b <= rs_b;
      o_rt_b <= rt_b;
   end

endmodule

// File: verilog/lc4_regfile_2w.sv
`timescale 1ns/1ps
`include "lc4_defs.svh"

module lc4_regfile_2w (
   input  logic                gwe,
   input  logic                i_reset,
   input  lc4_pkg::reg_sel_t   i_rs_a,
   input  lc4_pkg::reg_sel_t   i_rt_a,
   input  lc4_pkg::reg_sel_t   i_rs_b,
   input  lc4_pkg::reg_sel_t   i_rt_b,
   output lc4_pkg::word_t      o_rs_data_a,
   output lc4_pkg::word_t      o_rt_data_a,
   output lc4_pkg::word_t      o_rs_data_b,
   output lc4_pkg::word_t      o_rt_data_b,
   input  lc4_pkg::reg_write_t i_write_a,
   input  lc4_pkg::reg_write_t i_write_b
);

   lc4_pkg::word_t regs [`LC4_NREGS];

   // reads are write-through and check B first to match the array update
   function automatic lc4_pkg::word_t read_port(input lc4_pkg::reg_sel_t sel);
      if (i_write_b.we && i_write_b.sel == sel)
         return i_write_b.data;
      if (i_write_a.we && i_write_a.sel == sel)
         return i_write_a.data;
      return regs[sel];
   endfunction

   always_comb begin
      o_rs_data_a = read_port(i_rs_a);
      o_rt_data_a = read_port(i_rt_a);
      o_rs_data_b = read_port(i_rs_b);
      o_rt_data_b = read_port(i_rt_b);
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < `LC4_NREGS; i++)
            regs[i] <= '0;
      end else begin
         if (i_write_a.we)
            regs[i_write_a.sel] <= i_write_a.data;
         if (i_write_b.we)
            regs[i_write_b.sel] <= i_write_b.data;   // the later update lets B win
      end
   end

endmodule

// File: verilog/lc4_decoder.sv
`timescale 1ns/1ps
`include "lc4_defs.svh"

module lc4_decoder (
   input  lc4_pkg::word_t i_insn,
   output lc4_pkg::ctrl_t o_ctrl
);

   lc4_pkg::word_t imm5;
   lc4_pkg::word_t imm6;
   lc4_pkg::word_t imm9;

   assign imm5 = {{(`LC4_XLEN-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{(`LC4_XLEN-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{(`LC4_XLEN-9){i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      o_ctrl      = '0;
      o_ctrl.rs   = i_insn[`LC4_F_RS];
      o_ctrl.rt   = i_insn[`LC4_F_RT];
      o_ctrl.wsel = i_insn[`LC4_F_RD];
      case (i_insn[`LC4_F_OP])
         `LC4_OP_ARITH: begin
            if (i_insn[5]) begin   // add immediate
               o_ctrl.alu_op = lc4_pkg::ALU_ADDI;
               o_ctrl.imm    = imm5;
               o_ctrl.rs_re  = 1'b1;
               o_ctrl.rf_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
            end else if (i_insn[`LC4_F_SUB] == `LC4_SUB_ADD ||
                         i_insn[`LC4_F_SUB] == `LC4_SUB_SUB) begin
               o_ctrl.alu_op = (i_insn[`LC4_F_SUB] == `LC4_SUB_SUB) ?
                               lc4_pkg::ALU_SUB : lc4_pkg::ALU_ADD;
               o_ctrl.rs_re  = 1'b1;
               o_ctrl.rt_re  = 1'b1;
               o_ctrl.rf_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
            end
            // mul and div are not in the subset
         end
         `LC4_OP_CONST: begin
            o_ctrl.alu_op = lc4_pkg::ALU_CONST;
            o_ctrl.imm    = imm9;
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
         end
         `LC4_OP_LDR: begin
            o_ctrl.alu_op  = lc4_pkg::ALU_ADDI;
            o_ctrl.imm     = imm6;
            o_ctrl.rs_re   = 1'b1;
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.is_load = 1'b1;
         end
         `LC4_OP_STR: begin
            o_ctrl.alu_op   = lc4_pkg::ALU_ADDI;
            o_ctrl.imm      = imm6;
            o_ctrl.rt       = i_insn[`LC4_F_RD];   // store data register
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_re    = 1'b1;
            o_ctrl.is_store = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// File: verilog/lc4_fetch_pair.sv
`timescale 1ns/1ps
`include "lc4_defs.svh"

module lc4_fetch_pair (
   input  logic           gwe,
   input  logic           i_reset,
   input  lc4_pkg::word_t i_insn_a,
   input  lc4_pkg::word_t i_insn_b,
   input  logic           i_split,
   output lc4_pkg::word_t o_cur_pc,
   output lc4_pkg::slot_t o_slot_a,
   output lc4_pkg::slot_t o_slot_b
);

   lc4_pkg::word_t pc_q;       // fetch address assuming no split
   lc4_pkg::word_t fetch_pc;   // address of the pair now on i_insn_a/b

   function automatic lc4_pkg::slot_t make_slot(input lc4_pkg::word_t pc,
                                                input lc4_pkg::word_t insn);
      return '{pc: pc, insn: insn, ctrl: '0, stall: lc4_pkg::STALL_NONE};
   endfunction

   // instruction memory answers one cycle late, so a split pulls the next
   // fetch back by one word right away
   assign o_cur_pc = pc_q - lc4_pkg::word_t'(i_split);

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc_q     <= `LC4_RESET_PC;
         fetch_pc <= `LC4_RESET_PC;
         o_slot_a <= lc4_pkg::SLOT_FLUSH;
         o_slot_b <= lc4_pkg::SLOT_FLUSH;
      end else begin
         pc_q     <= o_cur_pc + lc4_pkg::word_t'(2);
         fetch_pc <= o_cur_pc;
         if (i_split) begin
            o_slot_a <= o_slot_b;   // held B moves up to pipe A
            o_slot_b <= make_slot(fetch_pc, i_insn_a);
         end else begin
            o_slot_a <= make_slot(fetch_pc, i_insn_a);
            o_slot_b <= make_slot(fetch_pc + lc4_pkg::word_t'(1), i_insn_b);
         end
      end
   end

endmodule

// File: verilog/lc4_reg_write_if.sv
`timescale 1ns/1ps

// writeback of both pipes into the register file
interface lc4_reg_write_if;

   lc4_pkg::reg_write_t wr_a;
   lc4_pkg::reg_write_t wr_b;   // wins over wr_a on the same register

   modport writer (
      output wr_a,
      output wr_b
   );

   modport reader (
      input wr_a,
      input wr_b
   );

endinterface

// File: verilog/lc4_pkg.sv
`include "lc4_defs.svh"

package lc4_pkg;

   typedef logic [`LC4_XLEN-1:0] word_t;
   typedef logic [$clog2(`LC4_NREGS)-1:0] reg_sel_t;
   typedef logic [2:0] nzp_t;   // {n, z, p}

   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_SPLIT = 2'd1,   // B slot bubbled because the pair could not issue together
      STALL_FLUSH = 2'd2    // slot emptied by reset
   } stall_t;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_ADDI,   // rs plus imm for ADD immediate and load/store addresses
      ALU_CONST
   } alu_op_t;

   typedef struct packed {
      reg_sel_t rs;
      logic     rs_re;
      reg_sel_t rt;
      logic     rt_re;
      reg_sel_t wsel;
      logic     rf_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      alu_op_t  alu_op;
      word_t    imm;        // already sign extended
   } ctrl_t;

   typedef struct packed {
      word_t  pc;
      word_t  insn;
      ctrl_t  ctrl;
      stall_t stall;
   } slot_t;

   typedef struct packed {
      logic     we;
      reg_sel_t sel;
      word_t    data;
   } reg_write_t;

   // insn 0 is a nop, so a flushed slot decodes with every enable low
   localparam slot_t SLOT_FLUSH = '{pc: '0, insn: '0, ctrl: '0, stall: STALL_FLUSH};

endpackage

// File: verilog/lc4_defs.svh
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

`define LC4_XLEN      16
`define LC4_NREGS     8
`define LC4_RESET_PC  16'h8200

// anything outside these opcodes decodes as a nop
`define LC4_OP_ARITH  4'b0001
`define LC4_OP_LDR    4'b0110
`define LC4_OP_STR    4'b0111
`define LC4_OP_CONST  4'b1001

`define LC4_SUB_ADD   3'b000
`define LC4_SUB_SUB   3'b010

`define LC4_F_OP      15:12
`define LC4_F_RD      11:9   // also the source register of STR
`define LC4_F_RS      8:6
`define LC4_F_SUB     5:3
`define LC4_F_RT      2:0

`endif
